// ==== src/br_uop_pkg.sv ====
package br_uop_pkg;

    // datapath and tag widths
    localparam int xlen    = 32;
    localparam int prf_idx = 6;
    localparam int rob_idx = 5;
    localparam int arf_idx = 5;

    typedef enum logic [3:0] {
        br_beq  = 4'd0,
        br_bne  = 4'd1,
        br_blt  = 4'd2,
        br_bge  = 4'd3,
        br_bltu = 4'd4,
        br_bgeu = 4'd5,
        br_jal  = 4'd6,
        br_jalr = 4'd7
    } br_op_e;

    // renamed micro-op as it leaves dispatch
    typedef struct packed {
        logic [rob_idx-1:0] rob_id;
        logic [prf_idx-1:0] rs1_phy;
        logic               rs1_valid;
        logic [prf_idx-1:0] rs2_phy;
        logic               rs2_valid;
        logic [prf_idx-1:0] rd_phy;
        logic [arf_idx-1:0] rd_arch;
        logic [xlen-1:0]    imm;
        logic [xlen-1:0]    pc;
        br_op_e             op;
        logic               predict_taken;
        logic [xlen-1:0]    predict_target;
    } br_uop_t;

    // issued micro-op, source tags replaced by operand values
    typedef struct packed {
        logic [rob_idx-1:0] rob_id;
        logic [prf_idx-1:0] rd_phy;
        logic [arf_idx-1:0] rd_arch;
        logic [xlen-1:0]    imm;
        logic [xlen-1:0]    pc;
        br_op_e             op;
        logic               predict_taken;
        logic [xlen-1:0]    predict_target;
        logic [xlen-1:0]    rs1_value;
        logic [xlen-1:0]    rs2_value;
    } br_issue_t;

endpackage

// ==== src/br_result_pkg.sv ====
package br_result_pkg;

    import br_uop_pkg::*;

    // one common data bus broadcast
    typedef struct packed {
        logic               valid;
        logic [prf_idx-1:0] rd_phy;
        logic [arf_idx-1:0] rd_arch;
        logic [rob_idx-1:0] rob_id;
        logic [xlen-1:0]    value;
    } cdb_t;

    // branch outcome sent back towards the ROB
    typedef struct packed {
        logic               valid;
        logic [rob_idx-1:0] rob_id;
        logic               taken;
        logic [xlen-1:0]    target;
        logic               mispredict;
        logic [xlen-1:0]    next_pc;
    } br_resolve_t;

endpackage

// ==== src/phys_regfile.sv ====
`timescale 1ns/1ns

module phys_regfile
    import br_uop_pkg::*;
    import br_result_pkg::*;
#(
    parameter int CDB_WIDTH = 2
) (
    input  logic               clk,
    input  cdb_t               cdb_in [CDB_WIDTH],
    input  logic [prf_idx-1:0] rs1_tag,
    input  logic [prf_idx-1:0] rs2_tag,
    output logic [xlen-1:0]    rs1_value,
    output logic [xlen-1:0]    rs2_value
);

    localparam int num_regs = 2 ** prf_idx;

    logic [xlen-1:0] regs [num_regs];

    // stored value, overridden by the highest matching cdb entry
    function automatic logic [xlen-1:0] read_port(input logic [prf_idx-1:0] tag);
        logic [xlen-1:0] data;
        data = regs[tag];
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb_in[k].valid && (cdb_in[k].rd_phy == tag)) begin
                data = cdb_in[k].value;
            end
        end
        return data;
    endfunction

    // write every valid broadcast at the edge
    always_ff @(posedge clk) begin
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb_in[k].valid) begin
                regs[cdb_in[k].rd_phy] <= cdb_in[k].value;
            end
        end
    end

    always_comb begin
        rs1_value = read_port(rs1_tag);
        rs2_value = read_port(rs2_tag);
    end

endmodule

// ==== src/fu_br.sv ====
`timescale 1ns/1ns

module fu_br
    import br_uop_pkg::*;
    import br_result_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        issue_valid,
    input  br_issue_t   issue,
    output cdb_t        cdb_out,
    output br_resolve_t br_resolve
);

    logic            taken;
    logic            is_jump;
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;
    logic [xlen-1:0] next_pc;
    logic            mispredict;

    ////////////////////////////////////////////////////////////
    // condition and target
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.op)
            br_beq:  taken = (issue.rs1_value == issue.rs2_value);
            br_bne:  taken = (issue.rs1_value != issue.rs2_value);
            br_blt:  taken = ($signed(issue.rs1_value) < $signed(issue.rs2_value));
            br_bge:  taken = ($signed(issue.rs1_value) >= $signed(issue.rs2_value));
            br_bltu: taken = (issue.rs1_value < issue.rs2_value);
            br_bgeu: taken = (issue.rs1_value >= issue.rs2_value);
            br_jal:  taken = 1'b1;
            br_jalr: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = (issue.op == br_jal) || (issue.op == br_jalr);
    assign link    = issue.pc + 32'd4;

    always_comb begin
        if (issue.op == br_jalr) begin
            // jalr drops bit 0 of the sum
            target = (issue.rs1_value + issue.imm) & ~32'd1;
        end else begin
            target = issue.pc + issue.imm;
        end
    end

    assign next_pc    = taken ? target : link;
    assign mispredict = (issue.predict_taken != taken)
                        || (taken && (issue.predict_target != target));

    ////////////////////////////////////////////////////////////
    // result registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            br_resolve.valid <= 1'b0;
            cdb_out.valid    <= 1'b0;
        end else begin
            br_resolve.valid <= issue_valid;
            cdb_out.valid    <= issue_valid && is_jump;
        end

        if (issue_valid) begin
            br_resolve.rob_id     <= issue.rob_id;
            br_resolve.taken      <= taken;
            br_resolve.target     <= target;
            br_resolve.mispredict <= mispredict;
            br_resolve.next_pc    <= next_pc;
            // link write for jal/jalr
            cdb_out.rd_phy        <= issue.rd_phy;
            cdb_out.rd_arch       <= issue.rd_arch;
            cdb_out.rob_id        <= issue.rob_id;
            cdb_out.value         <= link;
        end
    end

endmodule

// ==== src/br_rs.sv ====
`timescale 1ns/1ns

module br_rs
    import br_uop_pkg::*;
    import br_result_pkg::*;
#(
    parameter int RS_DEPTH  = 4,
    parameter int CDB_WIDTH = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               dispatch_valid,
    input  br_uop_t            dispatch_uop,
    output logic               dispatch_ready,
    input  cdb_t               cdb_in [CDB_WIDTH],
    output logic [prf_idx-1:0] rs1_tag,
    output logic [prf_idx-1:0] rs2_tag,
    input  logic [xlen-1:0]    rs1_value,
    input  logic [xlen-1:0]    rs2_value,
    output cdb_t               cdb_out,
    output br_resolve_t        br_resolve
);

    localparam int idx_w = $clog2(RS_DEPTH);

    br_uop_t             entries [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy;

    logic                push_en;
    logic [idx_w-1:0]    push_idx;
    logic                sel_en;
    logic [idx_w-1:0]    sel_idx;
    br_uop_t             sel_uop;

    logic                issue_valid;
    br_issue_t           issue;

    // source counts as ready if marked or broadcast this cycle
    function automatic logic src_ready(input logic [prf_idx-1:0] tag, input logic valid);
        logic hit;
        hit = valid;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb_in[k].valid && (cdb_in[k].rd_phy == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    ////////////////////////////////////////////////////////////
    // allocation
    ////////////////////////////////////////////////////////////

    assign dispatch_ready = ~&busy;
    assign push_en        = dispatch_valid && dispatch_ready;

    // lowest free entry
    always_comb begin
        push_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                push_idx = idx_w'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // issue select, lowest ready index wins
    ////////////////////////////////////////////////////////////

    always_comb begin
        sel_en  = 1'b0;
        sel_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (busy[i]
                && src_ready(entries[i].rs1_phy, entries[i].rs1_valid)
                && src_ready(entries[i].rs2_phy, entries[i].rs2_valid)) begin
                sel_en  = 1'b1;
                sel_idx = idx_w'(i);
            end
        end
    end

    assign sel_uop = entries[sel_idx];
    assign rs1_tag = sel_uop.rs1_phy;
    assign rs2_tag = sel_uop.rs2_phy;

    ////////////////////////////////////////////////////////////
    // entry state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy <= '0;
        end else begin
            if (push_en) begin
                busy[push_idx] <= 1'b1;
            end
            if (sel_en) begin
                busy[sel_idx] <= 1'b0;
            end
        end

        // cdb wakeup of waiting entries
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (busy[i]) begin
                entries[i].rs1_valid <= src_ready(entries[i].rs1_phy, entries[i].rs1_valid);
                entries[i].rs2_valid <= src_ready(entries[i].rs2_phy, entries[i].rs2_valid);
            end
        end

        // a tag broadcast while the uop is being pushed is caught here too
        if (push_en) begin
            entries[push_idx]           <= dispatch_uop;
            entries[push_idx].rs1_valid <= src_ready(dispatch_uop.rs1_phy,
                                                     dispatch_uop.rs1_valid);
            entries[push_idx].rs2_valid <= src_ready(dispatch_uop.rs2_phy,
                                                     dispatch_uop.rs2_valid);
        end
    end

    // issue register, operands captured with their bypass
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= sel_en;
        end

        if (sel_en) begin
            issue.rob_id         <= sel_uop.rob_id;
            issue.rd_phy         <= sel_uop.rd_phy;
            issue.rd_arch        <= sel_uop.rd_arch;
            issue.imm            <= sel_uop.imm;
            issue.pc             <= sel_uop.pc;
            issue.op             <= sel_uop.op;
            issue.predict_taken  <= sel_uop.predict_taken;
            issue.predict_target <= sel_uop.predict_target;
            issue.rs1_value      <= rs1_value;
            issue.rs2_value      <= rs2_value;
        end
    end

    fu_br u_fu_br (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb_out     (cdb_out),
        .br_resolve  (br_resolve)
    );

endmodule

// ==== src/br_cluster.sv ====
`timescale 1ns/1ns

module br_cluster
    import br_uop_pkg::*;
    import br_result_pkg::*;
#(
    parameter int RS_DEPTH  = 4,
    parameter int CDB_WIDTH = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        dispatch_valid,
    input  br_uop_t     dispatch_uop,
    output logic        dispatch_ready,
    input  cdb_t        cdb_in [CDB_WIDTH],
    output cdb_t        cdb_out,
    output br_resolve_t br_resolve
);

    // operand read path between station and register file
    logic [prf_idx-1:0] rs1_tag;
    logic [prf_idx-1:0] rs2_tag;
    logic [xlen-1:0]    rs1_value;
    logic [xlen-1:0]    rs2_value;

    br_rs #(
        .RS_DEPTH  (RS_DEPTH),
        .CDB_WIDTH (CDB_WIDTH)
    ) u_br_rs (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb_in         (cdb_in),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .cdb_out        (cdb_out),
        .br_resolve     (br_resolve)
    );

    phys_regfile #(
        .CDB_WIDTH (CDB_WIDTH)
    ) u_phys_regfile (
        .clk       (clk),
        .cdb_in    (cdb_in),
        .rs1_tag   (rs1_tag),
        .rs2_tag   (rs2_tag),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

endmodule

// ==== verif/br_cluster_props.sv ====
`timescale 1ns/1ns

module br_cluster_props
    import br_result_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input logic        clk,
    input logic        rst_n,
    input logic        flush,
    input logic        dispatch_valid,
    input logic        dispatch_ready,
    input logic        sel_en,
    input cdb_t        cdb_out,
    input br_resolve_t br_resolve
);

    // entries held, counted from accepted pushes and issues
    int occupancy;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(dispatch_valid && dispatch_ready) - int'(sel_en);
        end
    end

    // ready may only drop once every entry is taken
    ready_tracks_free: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy < RS_DEPTH) |-> dispatch_ready)
        else $error("dispatch_ready low while an entry is free");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy >= RS_DEPTH) |-> !(dispatch_valid && dispatch_ready))
        else $error("push accepted while the station is full");

    // flush kills both result strobes and the issue register behind them
    quiet_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (!(br_resolve.valid || cdb_out.valid)) [*2])
        else $error("result strobe in the cycles after a flush");

endmodule

bind br_rs br_cluster_props #(
    .RS_DEPTH (RS_DEPTH)
) u_br_cluster_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .sel_en         (sel_en),
    .cdb_out        (cdb_out),
    .br_resolve     (br_resolve)
);

// ==== verif/tb_br_cluster.sv ====
`timescale 1ns/1ns

module tb_br_cluster
    import br_uop_pkg::*;
    import br_result_pkg::*;
();

    localparam int rs_depth       = 4;
    localparam int cdb_width      = 2;
    localparam int timeout_cycles = 20;

    logic               clk;
    logic               rst_n;
    logic               flush;
    logic               dispatch_valid;
    br_uop_t            dispatch_uop;
    logic               dispatch_ready;
    cdb_t               cdb_in [cdb_width];
    cdb_t               cdb_out;
    br_resolve_t        br_resolve;

    // register values as broadcast by the testbench
    logic [xlen-1:0]    model_regs [64];
    logic [rob_idx-1:0] next_rob;
    br_uop_t            held [rs_depth];

    br_cluster #(
        .RS_DEPTH  (rs_depth),
        .CDB_WIDTH (cdb_width)
    ) u_br_cluster (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb_in         (cdb_in),
        .cdb_out        (cdb_out),
        .br_resolve     (br_resolve)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_resolve(input br_resolve_t got, input br_resolve_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] br_resolve got %h expected %h", got, exp));
        end
    endtask

    // for non-jumps only the strobe matters
    task automatic check_cdb(input cdb_t got, input cdb_t exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            fail_now($sformatf("[FAIL] cdb_out got %h expected %h", got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic br_resolve_t expect_resolve(input br_uop_t u);
        br_resolve_t     r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] sum;
        a = model_regs[u.rs1_phy];
        b = model_regs[u.rs2_phy];
        r.valid  = 1'b1;
        r.rob_id = u.rob_id;
        case (u.op)
            br_beq:  r.taken = (a == b);
            br_bne:  r.taken = (a != b);
            br_blt:  r.taken = ($signed(a) < $signed(b));
            br_bge:  r.taken = !($signed(a) < $signed(b));
            br_bltu: r.taken = (a < b);
            br_bgeu: r.taken = !(a < b);
            br_jal, br_jalr: r.taken = 1'b1;
            default: r.taken = 1'b0;
        endcase
        sum      = a + u.imm;
        r.target = (u.op == br_jalr) ? {sum[xlen-1:1], 1'b0} : u.pc + u.imm;
        r.next_pc = r.taken ? r.target : u.pc + 32'd4;
        r.mispredict = (u.predict_taken != r.taken)
                       || (r.taken && u.predict_target != r.target);
        return r;
    endfunction

    function automatic cdb_t expect_cdb(input br_uop_t u);
        cdb_t c;
        c         = '0;
        c.valid   = (u.op == br_jal) || (u.op == br_jalr);
        c.rd_phy  = u.rd_phy;
        c.rd_arch = u.rd_arch;
        c.rob_id  = u.rob_id;
        c.value   = u.pc + 32'd4;
        return c;
    endfunction

    function automatic br_uop_t make_uop(input br_op_e op, input logic [prf_idx-1:0] rs1,
                                         input logic [prf_idx-1:0] rs2,
                                         input logic [rob_idx-1:0] rob);
        br_uop_t u;
        u           = '0;
        u.rob_id    = rob;
        u.rs1_phy   = rs1;
        u.rs1_valid = 1'b1;
        u.rs2_phy   = rs2;
        u.rs2_valid = 1'b1;
        u.rd_phy    = 6'd32 + 6'(rob);
        u.rd_arch   = arf_idx'(rob);
        u.imm       = $urandom;
        u.pc        = $urandom & ~32'd3;
        u.op        = op;
        return u;
    endfunction

    // 0 correct, 1 wrong direction, 2 taken with wrong target
    function automatic br_uop_t predict(input br_uop_t u, input int mode);
        br_resolve_t r;
        r = expect_resolve(u);
        u.predict_taken  = (mode == 1) ? !r.taken : (mode == 2) ? 1'b1 : r.taken;
        u.predict_target = (mode == 2) ? r.target + 32'd8 : r.target;
        return u;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus tasks, all entered on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic set_lane(input int lane, input logic [prf_idx-1:0] tag,
                            input logic [xlen-1:0] value);
        cdb_in[lane].valid  = 1'b1;
        cdb_in[lane].rd_phy = tag;
        cdb_in[lane].value  = value;
        model_regs[tag]     = value;
    endtask

    task automatic end_broadcast();
        @(negedge clk);
        for (int k = 0; k < cdb_width; k++) begin
            cdb_in[k] = '0;
        end
    endtask

    task automatic dispatch(input br_uop_t u);
        int waited;
        waited = 0;
        while (!dispatch_ready) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                fail_now("dispatch_ready never came back high");
            end
        end
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_result(output int cycles);
        cycles = 0;
        while (!br_resolve.valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                fail_now("no branch result appeared before the timeout");
            end
        end
    endtask

    task automatic run_op(input br_op_e op, input logic [prf_idx-1:0] rs1,
                          input logic [prf_idx-1:0] rs2, input int mode, input bit check_lat);
        br_uop_t u;
        int      c;
        u        = predict(make_uop(op, rs1, rs2, next_rob), mode);
        next_rob = next_rob + 1'b1;
        dispatch(u);
        wait_result(c);
        if (check_lat && c != 2) begin
            fail_now($sformatf("result took %0d cycles after accept instead of 2", c));
        end
        check_resolve(br_resolve, expect_resolve(u));
        check_cdb(cdb_out, expect_cdb(u));
        @(negedge clk);
    endtask

    // park one uop per entry, all waiting on both tags
    task automatic fill_waiting(input logic [prf_idx-1:0] tag_a, input logic [prf_idx-1:0] tag_b);
        for (int i = 0; i < rs_depth; i++) begin
            held[i]           = make_uop(br_op_e'(i), tag_a, tag_b, 5'd16 + 5'(i));
            held[i].rs1_valid = 1'b0;
            held[i].rs2_valid = 1'b0;
            dispatch(held[i]);
        end
        if (dispatch_ready) begin
            fail_now("dispatch_ready stayed high with every entry taken");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic all_ops_resolve();
        for (int i = 0; i < 8; i++) begin
            run_op(br_op_e'(i), 1, 2, 0, 1'b1);
            run_op(br_op_e'(i), 3, 4, 0, 1'b1);
        end
    endtask

    task automatic mispredict_cases();
        run_op(br_beq, 1, 2, 1, 1'b1);
        run_op(br_bne, 1, 2, 1, 1'b1);
        run_op(br_bge, 1, 2, 2, 1'b1);
        run_op(br_jal, 3, 4, 2, 1'b1);
        run_op(br_jalr, 3, 4, 2, 1'b1);
    endtask

    task automatic wait_for_tag();
        br_uop_t u;
        int      c;
        u           = make_uop(br_bltu, 50, 4, 5'd24);
        u.rs1_valid = 1'b0;
        dispatch(u);
        repeat (5) begin
            if (br_resolve.valid) begin
                fail_now("branch resolved before its source tag was broadcast");
            end
            @(negedge clk);
        end
        set_lane(1, 50, $urandom);
        end_broadcast();
        wait_result(c);
        // issue in the broadcast cycle puts the result one edge later
        if (c != 1) begin
            fail_now("wakeup did not issue in the same cycle as the broadcast");
        end
        check_resolve(br_resolve, expect_resolve(u));
        check_cdb(cdb_out, expect_cdb(u));
        @(negedge clk);
    endtask

    task automatic fill_and_drain();
        int c;
        fill_waiting(40, 41);
        set_lane(0, 40, $urandom);
        set_lane(1, 41, $urandom);
        end_broadcast();
        wait_result(c);
        for (int i = 0; i < rs_depth; i++) begin
            check_resolve(br_resolve, expect_resolve(held[i]));
            check_cdb(cdb_out, expect_cdb(held[i]));
            @(negedge clk);
        end
    endtask

    task automatic flush_when_full();
        fill_waiting(60, 61);
        // the parked uops wake up in the flush cycle itself
        set_lane(0, 60, $urandom);
        set_lane(1, 61, $urandom);
        flush = 1'b1;
        end_broadcast();
        flush = 1'b0;
        if (!dispatch_ready) begin
            fail_now("dispatch_ready stayed low after the flush");
        end
        repeat (4) begin
            if (br_resolve.valid || cdb_out.valid) begin
                fail_now("a result came out after the flush");
            end
            @(negedge clk);
        end
        run_op(br_jalr, 3, 4, 0, 1'b1);
        run_op(br_blt, 3, 4, 1, 1'b1);
    endtask

    initial begin
        logic [xlen-1:0] v;
        void'($urandom(32'hb64b));
        clk            = 1'b0;
        rst_n          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        next_rob       = '0;
        for (int k = 0; k < cdb_width; k++) begin
            cdb_in[k] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (!dispatch_ready || br_resolve.valid || cdb_out.valid) begin
            fail_now("station not idle after reset");
        end

        // equal pair in 1/2, negative and positive in 3/4
        v = $urandom;
        set_lane(0, 1, v);
        set_lane(1, 2, v);
        end_broadcast();
        set_lane(0, 3, $urandom | 32'h8000_0000);
        set_lane(1, 4, $urandom & 32'h7fff_ffff);
        end_broadcast();

        all_ops_resolve();
        mispredict_cases();
        wait_for_tag();
        fill_and_drain();
        flush_when_full();

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== br_cluster.f ====
src/br_uop_pkg.sv
src/br_result_pkg.sv
src/phys_regfile.sv
src/fu_br.sv
src/br_rs.sv
src/br_cluster.sv
verif/br_cluster_props.sv
verif/tb_br_cluster.sv

// ==== Bender.yml ====
package:
  name: br_cluster

sources:
  - src/br_uop_pkg.sv
  - src/br_result_pkg.sv
  - src/phys_regfile.sv
  - src/fu_br.sv
  - src/br_rs.sv
  - src/br_cluster.sv
  - target: test
    files:
      - verif/br_cluster_props.sv
      - verif/tb_br_cluster.sv
